/* files.f */
+incdir+tests
hw/armCorePkg.sv
hw/regFile.sv
hw/aluUnit.sv
hw/immRotator.sv
hw/datapath.sv
hw/controlFsm.sv
hw/armCore.sv
tests/armCoreTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module armCoreTb -f files.f -o armCoreSim
out=$(./obj_dir/armCoreSim 2>&1) || true
echo "$out"
if echo "$out" | grep -q "TEST PASSED"; then
  exit 0
else
  exit 1
fi

/* tests/isaModel.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Architectural state of the reference model
logic [31:0] mRegs [0:14];
logic [31:0] mPc;
logic [3:0]  mFlags;
logic [31:0] mMem [0:63];

function automatic logic [31:0] rotRight(input logic [31:0] v, input logic [4:0] amt);
  return (v >> amt) | (v << (6'd32 - {1'b0, amt}));
endfunction

// R15 reads as the address of the instruction plus 4
function automatic logic [31:0] readReg(input logic [3:0] idx);
  if (idx == 4'd15)
    return mPc + 32'd4;
  return mRegs[idx];
endfunction

// ARM data-processing rules, flags packed as {n, z, c, v}
function automatic void aluRef(input logic [3:0] op, input logic [31:0] a,
                               input logic [31:0] b, input logic cIn,
                               output logic [31:0] res, output logic [3:0] nzcv);
  logic [32:0] s;
  logic [31:0] x;
  logic [31:0] y;
  logic        cin;
  logic        isSub;
  logic        arith;
  logic        c;
  logic        v;
  x     = a;
  y     = b;
  cin   = 1'b0;
  isSub = 1'b0;
  arith = 1'b1;
  res   = '0;
  case (op)
    4'd2, 4'd10: begin isSub = 1'b1; cin = 1'b1; end
    4'd3:        begin x = b; y = a; isSub = 1'b1; cin = 1'b1; end
    4'd4, 4'd11: cin = 1'b0;
    4'd5:        cin = cIn;
    4'd6:        begin isSub = 1'b1; cin = cIn; end
    4'd7:        begin x = b; y = a; isSub = 1'b1; cin = cIn; end
    default:     arith = 1'b0;
  endcase
  if (isSub)
    s = {1'b0, x} + {1'b0, ~y} + {32'd0, cin};
  else
    s = {1'b0, x} + {1'b0, y} + {32'd0, cin};
  case (op)
    4'd0, 4'd8: res = a & b;
    4'd1, 4'd9: res = a ^ b;
    4'd12:      res = a | b;
    4'd13:      res = b;
    4'd14:      res = a & ~b;
    4'd15:      res = ~b;
    default:    res = s[31:0];
  endcase
  c = arith ? s[32] : cIn;
  if (!arith)
    v = 1'b0;
  else if (isSub)
    v = (x[31] != y[31]) && (res[31] != x[31]);
  else
    v = (x[31] == y[31]) && (res[31] != x[31]);
  nzcv = {res[31], res == 32'd0, c, v};
endfunction

// Executes one instruction and predicts its data transfer, if any
function automatic void modelStep(input logic [31:0] ins, output logic hasData,
                                  output logic [7:0] dAdr, output logic dWe,
                                  output logic [31:0] dDat);
  logic [31:0] opB;
  logic [31:0] res;
  logic [3:0]  nzcv;
  logic [31:0] addr;
  logic [31:0] nextPc;
  hasData = 1'b0;
  dAdr    = '0;
  dWe     = 1'b0;
  dDat    = '0;
  nextPc  = mPc + 32'd4;
  if (ins[27:25] == 3'b000 || ins[27:25] == 3'b001)
  begin
    if (ins[25])
      opB = rotRight({24'd0, ins[7:0]}, {ins[11:8], 1'b0});
    else
      opB = readReg(ins[3:0]);
    aluRef(ins[24:21], readReg(ins[19:16]), opB, mFlags[1], res, nzcv);
    if (ins[24:23] != 2'b10 && ins[15:12] != 4'd15)
      mRegs[ins[15:12]] = res;
    if (ins[24:23] == 2'b10 || ins[20])
      mFlags = nzcv;
  end
  else if (ins[27:25] == 3'b010)
  begin
    if (ins[23])
      addr = readReg(ins[19:16]) + {20'd0, ins[11:0]};
    else
      addr = readReg(ins[19:16]) - {20'd0, ins[11:0]};
    hasData = 1'b1;
    dAdr    = addr[7:0];
    if (ins[20])
      mRegs[ins[15:12]] = mMem[addr[7:2]];
    else
    begin
      dWe              = 1'b1;
      dDat             = readReg(ins[15:12]);
      mMem[addr[7:2]]  = dDat;
    end
  end
  else if (ins[27:25] == 3'b101)
    nextPc = mPc + 32'd8 + {{6{ins[23]}}, ins[23:0], 2'b00};
  mPc = nextPc;
endfunction

`endif

/* tests/armCoreTb.sv */
`timescale 1ns/1ps

module armCoreTb;
  import armCorePkg::*;

  `include "isaModel.svh"

  localparam int PROG_LEN      = 56;
  localparam int MAX_WAIT      = 3;
  localparam int CYC_PER_INSTR = 2 * (MAX_WAIT + 2) + 4;
  localparam int TIMEOUT_NS    = (PROG_LEN + 20) * CYC_PER_INSTR * 10;

  logic        clk;
  logic        rstN;
  wbReq_t      wbReq;
  wbRsp_t      wbRsp;
  logic [31:0] mem [0:63];
  logic [31:0] lcgState;
  logic [1:0]  waitCnt;
  logic [31:0] prog [$];
  logic [31:0] selfBranch;
  logic [31:0] fetchedInstr;
  logic        expData;
  logic [7:0]  expAdr;
  logic        expWe;
  logic [31:0] expDat;
  logic        ackSeen;
  int          selfCount;

  armCore i_dut (
    .clk   (clk),
    .rstN  (rstN),
    .wbReq (wbReq),
    .wbRsp (wbRsp)
  );

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] encDpImm(input aluOp_e op, input int s, input int rn,
                                           input int rd, input int rot, input int imm);
    return {4'hE, 3'b001, op[3:0], 1'(s), 4'(rn), 4'(rd), 4'(rot), 8'(imm)};
  endfunction

  function automatic logic [31:0] encDpReg(input aluOp_e op, input int s, input int rn,
                                           input int rd, input int rm);
    return {4'hE, 3'b000, op[3:0], 1'(s), 4'(rn), 4'(rd), 8'd0, 4'(rm)};
  endfunction

  // Pre-indexed word access without writeback
  function automatic logic [31:0] encMem(input int l, input int u, input int rn,
                                         input int rd, input int off);
    return {4'hE, 3'b010, 1'b1, 1'(u), 2'b00, 1'(l), 4'(rn), 4'(rd), 12'(off)};
  endfunction

  function automatic logic [31:0] encBranch(input int off);
    return {4'hE, 3'b101, 1'b0, 24'(off)};
  endfunction

  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  initial clk = 1'b0;
  always #5 clk = ~clk;

  initial
  begin
    rstN  <= 1'b0;
    wbRsp <= '0;
    repeat (3) @(posedge clk);
    rstN <= 1'b1;
  end

  initial
  begin
    // Data lives in 0xE0 to 0xFC around the base in r13
    prog.push_back(encDpImm(opMov, 0, 0, 13, 0, 'hF0));
    prog.push_back(encDpImm(opMov, 1, 0, 1, 4, 'hC3));
    prog.push_back(encDpImm(opAnd, 0, 1, 2, 4, 'hFF));
    prog.push_back(encDpImm(opEor, 0, 1, 3, 0, 'h3C));
    prog.push_back(encDpImm(opSub, 0, 1, 4, 0, 1));
    prog.push_back(encDpImm(opRsb, 0, 1, 5, 0, 7));
    prog.push_back(encDpImm(opAdd, 1, 1, 6, 4, 'h50));
    prog.push_back(encDpImm(opAdc, 0, 1, 7, 0, 2));
    prog.push_back(encDpImm(opSbc, 0, 1, 8, 0, 2));
    prog.push_back(encDpImm(opRsc, 0, 1, 9, 0, 9));
    prog.push_back(encMem(0, 1, 13, 2, 0));
    prog.push_back(encMem(0, 1, 13, 3, 4));
    prog.push_back(encMem(0, 1, 13, 4, 8));
    prog.push_back(encMem(0, 1, 13, 5, 12));
    prog.push_back(encMem(0, 0, 13, 6, 4));
    prog.push_back(encMem(0, 0, 13, 7, 8));
    prog.push_back(encMem(0, 0, 13, 8, 12));
    prog.push_back(encMem(0, 0, 13, 9, 16));
    // Test opcodes aim at r13 and pass their carry to an ADC
    prog.push_back(encDpImm(opCmp, 0, 1, 13, 4, 'hFF));
    prog.push_back(encDpImm(opTst, 0, 1, 13, 0, 0));
    prog.push_back(encDpImm(opTeq, 0, 1, 13, 4, 'hC3));
    prog.push_back(encDpImm(opAdc, 0, 1, 10, 0, 0));
    prog.push_back(encDpImm(opCmn, 0, 1, 13, 4, 'h3D));
    prog.push_back(encDpImm(opAdc, 0, 1, 14, 0, 0));
    prog.push_back(encDpImm(opOrr, 0, 1, 11, 0, 'h11));
    prog.push_back(encDpImm(opBic, 0, 1, 12, 4, 'h03));
    prog.push_back(encDpImm(opMvn, 0, 0, 0, 0, 'h22));
    prog.push_back(encMem(0, 1, 13, 10, 0));
    prog.push_back(encMem(0, 1, 13, 14, 4));
    prog.push_back(encMem(0, 1, 13, 11, 8));
    prog.push_back(encMem(0, 1, 13, 12, 12));
    prog.push_back(encMem(0, 0, 13, 0, 4));
    // Register operands with signed overflow
    // SBC and RSC run with carry clear and ADC with carry set
    prog.push_back(encDpImm(opMov, 0, 0, 2, 4, 'h7F));
    prog.push_back(encDpReg(opAdd, 1, 2, 3, 2));
    prog.push_back(encDpReg(opSbc, 0, 1, 7, 2));
    prog.push_back(encDpReg(opRsc, 0, 2, 8, 1));
    prog.push_back(encDpReg(opSub, 1, 1, 4, 2));
    prog.push_back(encDpReg(opRsb, 1, 2, 6, 1));
    prog.push_back(encDpReg(opAdc, 0, 2, 5, 3));
    prog.push_back(encMem(0, 1, 13, 3, 0));
    prog.push_back(encMem(0, 1, 13, 5, 4));
    prog.push_back(encMem(0, 1, 13, 4, 8));
    prog.push_back(encMem(0, 1, 13, 6, 12));
    prog.push_back(encMem(0, 0, 13, 7, 4));
    prog.push_back(encMem(0, 0, 13, 8, 8));
    // Store and reload with both offset signs
    prog.push_back(encDpImm(opAdd, 0, 15, 9, 0, 0));
    prog.push_back(encMem(0, 0, 13, 9, 12));
    prog.push_back(encMem(1, 0, 13, 10, 12));
    prog.push_back(encMem(0, 1, 13, 6, 12));
    prog.push_back(encMem(1, 1, 13, 11, 12));
    prog.push_back(encMem(0, 1, 13, 10, 0));
    prog.push_back(encMem(0, 0, 13, 11, 16));
    // Forward past two words and back into the final loop
    prog.push_back(encBranch(1));
    prog.push_back(encDpImm(opMov, 0, 0, 0, 0, 'hEE));
    prog.push_back(encBranch(-2));
    prog.push_back(encBranch(-3));
    selfBranch = encBranch(-2);
    for (int i = 0; i < 64; i++)
    begin
      mem[i]  = 32'h9E3779B9 * 32'(i + 1);
      mMem[i] = mem[i];
    end
    for (int i = 0; i < prog.size(); i++)
    begin
      mem[i]  = prog[i];
      mMem[i] = prog[i];
    end
    mPc       = '0;
    mFlags    = '0;
    expData   = 1'b0;
    ackSeen   = 1'b0;
    selfCount = 0;
  end

  // Memory with 0 to 3 wait states per transfer
  always @(posedge clk)
  begin
    if (!rstN)
    begin
      wbRsp.ack <= 1'b0;
      lcgState  = 32'h770cd045;
      waitCnt   <= lcgState[17:16];
    end
    else if (wbRsp.ack)
      wbRsp.ack <= 1'b0;
    else if (wbReq.cyc && wbReq.stb)
    begin
      if (waitCnt == 2'd0)
      begin
        wbRsp.ack <= 1'b1;
        wbRsp.dat <= mem[wbReq.adr[7:2]];
        if (wbReq.we)
          mem[wbReq.adr[7:2]] = wbReq.dat;
        lcgState = lcgNext(lcgState);
        waitCnt  <= lcgState[17:16];
      end
      else
        waitCnt <= waitCnt - 2'd1;
    end
  end

  // Every completed transfer against the model
  always @(posedge clk)
  begin
    // Strobes are low in the cycle after an ack
    if (ackSeen)
    begin
      checkVal("wbReq.cyc", 32'(wbReq.cyc), 32'd0);
      checkVal("wbReq.stb", 32'(wbReq.stb), 32'd0);
    end
    ackSeen = rstN && wbReq.cyc && wbReq.stb && wbRsp.ack;
    if (ackSeen)
    begin
      if (expData)
      begin
        checkVal("wbReq.adr", 32'(wbReq.adr), 32'(expAdr));
        checkVal("wbReq.we", 32'(wbReq.we), 32'(expWe));
        if (expWe)
          checkVal("wbReq.dat", wbReq.dat, expDat);
        expData = 1'b0;
      end
      else
      begin
        checkVal("wbReq.adr", 32'(wbReq.adr), 32'(mPc[7:0]));
        checkVal("wbReq.we", 32'(wbReq.we), 32'd0);
        fetchedInstr = mMem[mPc[7:2]];
        if (fetchedInstr == selfBranch)
          selfCount++;
        if (selfCount == 2)
        begin
          $display("TEST PASSED");
          $finish;
        end
        else
          modelStep(fetchedInstr, expData, expAdr, expWe, expDat);
      end
    end
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("Watchdog fired: the core stopped making progress");
    $display("TEST FAILED");
    $fatal(1);
  end

endmodule

/* hw/armCore.sv */
`timescale 1ns/1ps

module armCore (
  input  logic               clk,
  input  logic               rstN,
  output armCorePkg::wbReq_t wbReq,
  input  armCorePkg::wbRsp_t wbRsp
);
  import armCorePkg::*;

  ctrl_t             ctrl;
  logic [DATA_W-1:0] instr;
  logic [DATA_W-1:0] wrData;
  logic [ADDR_W-1:0] adr;
  logic              cyc;
  logic              stb;
  logic              we;

  datapath uDatapath (
    .clk    (clk),
    .rstN   (rstN),
    .ctrl   (ctrl),
    .rdData (wbRsp.dat),
    .instr  (instr),
    .adr    (adr),
    .wrData (wrData)
  );

  controlFsm uControl (
    .clk   (clk),
    .rstN  (rstN),
    .instr (instr),
    .wbAck (wbRsp.ack),
    .ctrl  (ctrl),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we)
  );

  assign wbReq.cyc = cyc;
  assign wbReq.stb = stb;
  assign wbReq.we  = we;
  assign wbReq.adr = adr;
  assign wbReq.dat = wrData;

endmodule

/* hw/controlFsm.sv */
`timescale 1ns/1ps

module controlFsm (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic [armCorePkg::DATA_W-1:0] instr,
  input  logic                          wbAck,
  output armCorePkg::ctrl_t             ctrl,
  output logic                          cyc,
  output logic                          stb,
  output logic                          we
);
  import armCorePkg::*;

  coreState_e state;
  coreState_e nextState;
  logic [2:0] cls;
  logic [3:0] opcode;
  logic       sBit;
  logic       lBit;
  logic       uBit;
  logic       isTest;
  logic       xferDone;
  logic       busReq;
  logic       busWe;

  assign cls    = instr[27:25];
  assign opcode = instr[24:21];
  assign sBit   = instr[20];
  assign lBit   = instr[20];
  assign uBit   = instr[23];
  // TST, TEQ, CMP, CMN
  assign isTest = (opcode[3:2] == 2'b10);

  assign xferDone = busReq && wbAck;
  assign cyc      = busReq;
  assign stb      = busReq;
  assign we       = busWe;

  always_comb
  begin
    nextState     = state;
    ctrl          = '0;
    ctrl.aluOp    = opPassA;
    ctrl.aSel     = aRn;
    ctrl.bSel     = bRm;
    case (state)
      fetch:
      begin
        ctrl.irLoad = xferDone;
        ctrl.pcInc  = xferDone;
        if (xferDone)
          nextState = decode;
      end
      decode:
      begin
        case (cls)
          CLS_DP_REG, CLS_DP_IMM: nextState = execute;
          CLS_LDST:               nextState = memAddr;
          CLS_BRANCH:             nextState = branch;
          default:                nextState = fetch;
        endcase
      end
      execute:
      begin
        ctrl.aluOp     = aluOp_e'({1'b0, opcode});
        ctrl.bSel      = (cls == CLS_DP_IMM) ? bRotImm : bRm;
        ctrl.regWrite  = !isTest;
        ctrl.flagsLoad = isTest || sBit;
        nextState      = fetch;
      end
      memAddr:
      begin
        ctrl.aluOp   = uBit ? opAdd : opSub;
        ctrl.bSel    = bOffImm;
        ctrl.marLoad = 1'b1;
        ctrl.mdrLoad = !lBit;
        nextState    = memAccess;
      end
      memAccess:
      begin
        // Keep the address held until the last cycle of the transfer
        ctrl.aluOp    = uBit ? opAdd : opSub;
        ctrl.bSel     = bOffImm;
        ctrl.marLoad  = !xferDone;
        ctrl.regWrite = lBit && xferDone;
        if (xferDone)
          nextState = fetch;
      end
      branch:
      begin
        ctrl.aluOp  = opBrAdd;
        ctrl.aSel   = aPc;
        ctrl.bSel   = bBrOff;
        ctrl.pcLoad = 1'b1;
        nextState   = fetch;
      end
      default:
        nextState = fetch;
    endcase
  end

  // Strobes drop for a cycle after every ack
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state  <= fetch;
      busReq <= 1'b0;
      busWe  <= 1'b0;
    end
    else
    begin
      state  <= nextState;
      busReq <= (nextState == fetch || nextState == memAccess) && !xferDone;
      busWe  <= (nextState == memAccess) && !lBit && !xferDone;
    end
  end

endmodule

/* hw/datapath.sv */
`timescale 1ns/1ps

module datapath (
  input  logic                          clk,
  input  logic                          rstN,
  input  armCorePkg::ctrl_t             ctrl,
  input  logic [armCorePkg::DATA_W-1:0] rdData,
  output logic [armCorePkg::DATA_W-1:0] instr,
  output logic [armCorePkg::ADDR_W-1:0] adr,
  output logic [armCorePkg::DATA_W-1:0] wrData
);
  import armCorePkg::*;

  logic [ADDR_W-1:0]    mar;
  logic [DATA_W-1:0]    mdr;
  flags_t               flagsQ;
  flags_t               aluFlags;
  logic                 useMar;
  logic [REG_IDX_W-1:0] rdIdxB;
  logic [DATA_W-1:0]    rdA;
  logic [DATA_W-1:0]    rdB;
  logic [DATA_W-1:0]    pc;
  logic [DATA_W-1:0]    opA;
  logic [DATA_W-1:0]    opB;
  logic [DATA_W-1:0]    aluResult;
  logic [DATA_W-1:0]    regWrData;
  logic [DATA_W-1:0]    rotImm;
  logic [DATA_W-1:0]    offImm;
  logic [DATA_W-1:0]    brOff;

  // Port B reads Rm for register operands, Rd as store data otherwise
  assign rdIdxB = (ctrl.bSel == bRm) ? instr[3:0] : instr[15:12];

  regFile uRegFile (
    .clk    (clk),
    .rstN   (rstN),
    .rdIdxA (instr[19:16]),
    .rdIdxB (rdIdxB),
    .wrIdx  (instr[15:12]),
    .wrEn   (ctrl.regWrite),
    .wrData (regWrData),
    .pcLoad (ctrl.pcLoad),
    .pcInc  (ctrl.pcInc),
    .pcNext (aluResult),
    .rdA    (rdA),
    .rdB    (rdB),
    .pc     (pc)
  );

  immRotator uImm (
    .instr  (instr),
    .rotImm (rotImm),
    .offImm (offImm),
    .brOff  (brOff)
  );

  always_comb
  begin
    opA = (ctrl.aSel == aPc) ? pc : rdA;
    case (ctrl.bSel)
      bRotImm: opB = rotImm;
      bOffImm: opB = offImm;
      bBrOff:  opB = brOff;
      default: opB = rdB;
    endcase
  end

  aluUnit uAlu (
    .a       (opA),
    .b       (opB),
    .op      (ctrl.aluOp),
    .carryIn (flagsQ.c),
    .result  (aluResult),
    .flags   (aluFlags)
  );

  // useMar is high through the data access, so a write then comes from the bus
  assign regWrData = useMar ? rdData : aluResult;
  assign adr       = useMar ? mar : pc[ADDR_W-1:0];
  assign wrData    = mdr;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      flagsQ <= '0;
      useMar <= 1'b0;
    end
    else
    begin
      if (ctrl.flagsLoad)
        flagsQ <= aluFlags;
      useMar <= ctrl.marLoad;
    end
  end

  always_ff @(posedge clk)
  begin
    if (ctrl.irLoad)
      instr <= rdData;
    if (ctrl.marLoad)
      mar <= aluResult[ADDR_W-1:0];
    if (ctrl.mdrLoad)
      mdr <= rdB;
  end

endmodule

/* hw/immRotator.sv */
`timescale 1ns/1ps

module immRotator (
  input  logic [armCorePkg::DATA_W-1:0] instr,
  output logic [armCorePkg::DATA_W-1:0] rotImm,
  output logic [armCorePkg::DATA_W-1:0] offImm,
  output logic [armCorePkg::DATA_W-1:0] brOff
);
  import armCorePkg::*;

  logic [DATA_W-1:0]   imm8;
  logic [4:0]          rotAmt;
  logic [2*DATA_W-1:0] rotPair;

  assign imm8   = {{(DATA_W-8){1'b0}}, instr[7:0]};
  assign rotAmt = {instr[11:8], 1'b0};

  // Rotate right by shifting a doubled copy
  assign rotPair = {imm8, imm8} >> rotAmt;
  assign rotImm  = rotPair[DATA_W-1:0];

  assign offImm = {{(DATA_W-12){1'b0}}, instr[11:0]};

  // Word offset, sign extended and scaled to bytes
  assign brOff = {{(DATA_W-26){instr[23]}}, instr[23:0], 2'b00};

endmodule

/* hw/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
  input  logic [armCorePkg::DATA_W-1:0] a,
  input  logic [armCorePkg::DATA_W-1:0] b,
  input  armCorePkg::aluOp_e            op,
  input  logic                          carryIn,
  output logic [armCorePkg::DATA_W-1:0] result,
  output armCorePkg::flags_t            flags
);
  import armCorePkg::*;

  logic [DATA_W-1:0] x;
  logic [DATA_W-1:0] y;
  logic              cin;
  logic              arith;
  logic [DATA_W:0]   sum;

  // Adder operands, subtraction as x + ~y + 1
  always_comb
  begin
    x     = a;
    y     = b;
    cin   = 1'b0;
    arith = 1'b1;
    case (op)
      opAdd, opCmn:
        cin = 1'b0;
      opSub, opCmp:
      begin
        y   = ~b;
        cin = 1'b1;
      end
      opRsb:
      begin
        x   = b;
        y   = ~a;
        cin = 1'b1;
      end
      opAdc:
        cin = carryIn;
      opSbc:
      begin
        y   = ~b;
        cin = carryIn;
      end
      opRsc:
      begin
        x   = b;
        y   = ~a;
        cin = carryIn;
      end
      // Branch target is PC + 4 + offset
      opBrAdd:
        y = b + PC_STEP;
      default:
        arith = 1'b0;
    endcase
  end

  assign sum = {1'b0, x} + {1'b0, y} + {{DATA_W{1'b0}}, cin};

  always_comb
  begin
    case (op)
      opAnd, opTst: result = a & b;
      opEor, opTeq: result = a ^ b;
      opOrr:        result = a | b;
      opMov:        result = b;
      opBic:        result = a & ~b;
      opMvn:        result = ~b;
      opPassA:      result = a;
      default:      result = sum[DATA_W-1:0];
    endcase
  end

  assign flags.n = result[DATA_W-1];
  assign flags.z = (result == '0);
  // Carry out doubles as not-borrow for subtraction
  assign flags.c = arith ? sum[DATA_W] : carryIn;
  assign flags.v = arith && (x[DATA_W-1] == y[DATA_W-1]) && (sum[DATA_W-1] != x[DATA_W-1]);

endmodule

/* hw/regFile.sv */
`timescale 1ns/1ps

module regFile (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic [armCorePkg::REG_IDX_W-1:0] rdIdxA,
  input  logic [armCorePkg::REG_IDX_W-1:0] rdIdxB,
  input  logic [armCorePkg::REG_IDX_W-1:0] wrIdx,
  input  logic                             wrEn,
  input  logic [armCorePkg::DATA_W-1:0]    wrData,
  input  logic                             pcLoad,
  input  logic                             pcInc,
  input  logic [armCorePkg::DATA_W-1:0]    pcNext,
  output logic [armCorePkg::DATA_W-1:0]    rdA,
  output logic [armCorePkg::DATA_W-1:0]    rdB,
  output logic [armCorePkg::DATA_W-1:0]    pc
);
  import armCorePkg::*;

  // R0 to R14, R15 lives in pc
  logic [DATA_W-1:0] regs [0:NUM_REGS-2];

  always_ff @(posedge clk)
  begin
    if (wrEn && wrIdx != PC_IDX)
      regs[wrIdx] <= wrData;
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      pc <= '0;
    else if (pcLoad)
      pc <= pcNext;
    else if (pcInc)
      pc <= pc + PC_STEP;
  end

  assign rdA = (rdIdxA == PC_IDX) ? pc : regs[rdIdxA];
  assign rdB = (rdIdxB == PC_IDX) ? pc : regs[rdIdxB];

endmodule

/* hw/armCorePkg.sv */
package armCorePkg;

  localparam int DATA_W    = 32;
  localparam int ADDR_W    = 8;
  localparam int REG_IDX_W = 4;
  localparam int NUM_REGS  = 16;

  // Index of the program counter in the register space
  localparam logic [REG_IDX_W-1:0] PC_IDX = REG_IDX_W'(NUM_REGS - 1);
  localparam logic [DATA_W-1:0]    PC_STEP = DATA_W'(4);

  // Instruction class field, bits 27:25
  localparam logic [2:0] CLS_DP_REG = 3'b000;
  localparam logic [2:0] CLS_DP_IMM = 3'b001;
  localparam logic [2:0] CLS_LDST   = 3'b010;
  localparam logic [2:0] CLS_BRANCH = 3'b101;

  // Data-processing opcodes in ARM order, then the core's own operations
  typedef enum logic [4:0] {
    opAnd   = 5'd0,
    opEor   = 5'd1,
    opSub   = 5'd2,
    opRsb   = 5'd3,
    opAdd   = 5'd4,
    opAdc   = 5'd5,
    opSbc   = 5'd6,
    opRsc   = 5'd7,
    opTst   = 5'd8,
    opTeq   = 5'd9,
    opCmp   = 5'd10,
    opCmn   = 5'd11,
    opOrr   = 5'd12,
    opMov   = 5'd13,
    opBic   = 5'd14,
    opMvn   = 5'd15,
    opBrAdd = 5'd16,
    opPassA = 5'd17
  } aluOp_e;

  typedef enum logic [2:0] {
    fetch,
    decode,
    execute,
    memAddr,
    memAccess,
    branch
  } coreState_e;

  typedef enum logic {
    aRn,
    aPc
  } aSel_e;

  typedef enum logic [1:0] {
    bRm,
    bRotImm,
    bOffImm,
    bBrOff
  } bSel_e;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  typedef struct packed {
    aluOp_e aluOp;
    aSel_e  aSel;
    bSel_e  bSel;
    logic   regWrite;
    logic   irLoad;
    logic   marLoad;
    logic   mdrLoad;
    logic   flagsLoad;
    logic   pcInc;
    logic   pcLoad;
  } ctrl_t;

  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat;
  } wbReq_t;

  typedef struct packed {
    logic [DATA_W-1:0] dat;
    logic              ack;
  } wbRsp_t;

endpackage
